// File: Makefile
TOP = tb_uncached_dcache

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output"
	@echo "  help   show this list"

test:
	verilator --binary --timing -j 0 -f src.f --top-module $(TOP) -o $(TOP)
	./obj_dir/$(TOP)

clean:
	rm -rf obj_dir

// File: source/access_fsm.sv
// One request in flight; expects r_valid only after AR and b_valid only after both AW and W
module access_fsm import uncached_pkg::*; (
    input  logic      clk,
    input  logic      rstn,
    input  logic      req_valid,
    input  cpu_req_t  req,
    input  logic      misaligned,
    input  xlen_t     load_value,
    input  xlen_t     amo_result,
    input  logic      ar_ready,
    input  logic      r_valid,
    input  logic      aw_ready,
    input  logic      w_ready,
    input  logic      b_valid,
    output logic      req_ready,
    output logic      resp_valid,
    output cpu_resp_t resp,
    output cpu_req_t  held,
    output logic      ar_valid,
    output logic      aw_valid,
    output logic      w_valid,
    output xlen_t     bus_addr,
    output logic      r_ready,
    output logic      b_ready
);

    typedef enum logic [1:0] {
        IDLE,
        WAIT_R,   // AR issued, waiting for the read beat
        AMO,      // One cycle for the ALU result
        WAIT_W    // AW and W issued, waiting for B
    } state_t;

    state_t state;
    logic   accept;
    logic   exc_valid;
    xlen_t  resp_value;

    assign req_ready = state == IDLE;
    assign accept    = req_valid && req_ready;
    assign bus_addr  = held.addr;
    assign r_ready   = 1'b1;
    assign b_ready   = 1'b1;

    always_comb begin
        resp.value     = resp_value;
        resp.exc_valid = exc_valid;
        resp.exc_cause = held.op == MEM_LOAD ? EXC_LOAD_MISALIGN : EXC_STORE_MISALIGN;
        resp.tval      = held.addr;
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state      <= IDLE;
            resp_valid <= 1'b0;
            exc_valid  <= 1'b0;
            ar_valid   <= 1'b0;
            aw_valid   <= 1'b0;
            w_valid    <= 1'b0;
        end else begin
            resp_valid <= 1'b0;
            exc_valid  <= 1'b0;
            unique case (state)
                IDLE: begin
                    if (req_valid) begin
                        if (misaligned) begin
                            // Answer at once, no bus traffic
                            resp_valid <= 1'b1;
                            exc_valid  <= 1'b1;
                        end else if (req.op == MEM_LOAD || req.op == MEM_AMO) begin
                            ar_valid <= 1'b1;
                            state    <= WAIT_R;
                        end else begin
                            aw_valid <= 1'b1;
                            w_valid  <= 1'b1;
                            state    <= WAIT_W;
                        end
                    end
                end
                WAIT_R: begin
                    if (ar_ready) begin
                        ar_valid <= 1'b0;
                    end
                    if (r_valid) begin
                        ar_valid <= 1'b0;
                        if (held.op == MEM_AMO) begin
                            state <= AMO;
                        end else begin
                            resp_valid <= 1'b1;
                            state      <= IDLE;
                        end
                    end
                end
                AMO: begin
                    aw_valid <= 1'b1;   // held.value carries the result by now
                    w_valid  <= 1'b1;
                    state    <= WAIT_W;
                end
                WAIT_W: begin
                    if (aw_ready) begin
                        aw_valid <= 1'b0;
                    end
                    if (w_ready) begin
                        w_valid <= 1'b0;
                    end
                    if (b_valid) begin
                        aw_valid   <= 1'b0;
                        w_valid    <= 1'b0;
                        resp_valid <= 1'b1;
                        state      <= IDLE;
                    end
                end
            endcase
        end
    end

    // Request copy and response data
    always_ff @(posedge clk) begin
        if (accept) begin
            held <= req;
        end
        if (accept && misaligned) begin
            resp_value <= '0;
        end
        if (state == WAIT_R && r_valid) begin
            resp_value <= load_value;
        end
        if (state == AMO) begin
            held.value <= amo_result;   // Operand replaced by the write data
        end
        if (state == WAIT_W && b_valid && held.op != MEM_AMO) begin
            resp_value <= '0;   // Store and SC return 0, AMO keeps the old value
        end
    end

endmodule

// File: source/amo_alu.sv
// Full 64-bit compare only; word AMOs need sign-extended operands for min and max
module amo_alu import uncached_pkg::*; (
    input  xlen_t   original,   // Value read from memory
    input  xlen_t   operand,    // Value from the CPU
    input  amo_fn_t fn,
    output xlen_t   result
);

    logic lt_signed;
    logic lt_unsigned;

    assign lt_signed   = $signed(original) < $signed(operand);
    assign lt_unsigned = original < operand;

    always_comb begin
        unique case (fn)
            SWAP: result = operand;
            ADD:  result = original + operand;
            XOR:  result = original ^ operand;
            AND:  result = original & operand;
            OR:   result = original | operand;
            MIN:  result = lt_signed ? original : operand;
            MAX:  result = lt_signed ? operand : original;
            MINU: result = lt_unsigned ? original : operand;
            MAXU: result = lt_unsigned ? operand : original;
            // Unknown function leaves memory as it was
            default: result = original;
        endcase
    end

endmodule

// File: source/lane_aligner.sv
// Purely combinational; assumes size 3 accesses are doubleword aligned before lanes are used
module lane_aligner import uncached_pkg::*; (
    input  xlen_t    req_addr,
    input  size_t    req_size,
    input  cpu_req_t held,
    input  xlen_t    r_data,
    output logic     misaligned,
    output xlen_t    load_value,
    output wr_beat_t w
);

    logic [BYTE_OFS_W-1:0] ofs;
    xlen_t                 shifted;
    logic                  ext;
    strb_t                 mask;

    // Natural alignment of the incoming request
    always_comb begin
        unique case (req_size)
            2'd0: misaligned = 1'b0;
            2'd1: misaligned = req_addr[0];
            2'd2: misaligned = |req_addr[1:0];
            2'd3: misaligned = |req_addr[BYTE_OFS_W-1:0];
        endcase
    end

    assign ofs     = held.addr[BYTE_OFS_W-1:0];
    assign shifted = r_data >> {ofs, 3'b000};   // Selected lane down to bit 0

    always_comb begin
        ext = 1'b0;
        unique case (held.size)
            2'd0: begin
                ext        = ~held.is_unsigned & shifted[7];
                load_value = {{56{ext}}, shifted[7:0]};
            end
            2'd1: begin
                ext        = ~held.is_unsigned & shifted[15];
                load_value = {{48{ext}}, shifted[15:0]};
            end
            2'd2: begin
                ext        = ~held.is_unsigned & shifted[31];
                load_value = {{32{ext}}, shifted[31:0]};
            end
            2'd3: begin
                load_value = shifted;   // Nothing to extend
            end
        endcase
    end

    // One strobe bit per byte of the access
    always_comb begin
        unique case (held.size)
            2'd0: mask = 8'h01;
            2'd1: mask = 8'h03;
            2'd2: mask = 8'h0f;
            2'd3: mask = 8'hff;
        endcase
    end

    assign w.data = held.value << {ofs, 3'b000};
    assign w.strb = mask << ofs;

endmodule

// File: source/uncached_dcache.sv
// Uncached, one access at a time; bus addresses are the CPU addresses with no translation
module uncached_dcache import uncached_pkg::*; (
    input  logic      clk,
    input  logic      rstn,
    input  logic      req_valid,
    input  cpu_req_t  req,
    output logic      req_ready,
    output logic      resp_valid,
    output cpu_resp_t resp,
    output logic      ar_valid,
    output xlen_t     ar_addr,
    input  logic      ar_ready,
    input  logic      r_valid,
    input  xlen_t     r_data,
    output logic      r_ready,
    output logic      aw_valid,
    output xlen_t     aw_addr,
    input  logic      aw_ready,
    output logic      w_valid,
    output wr_beat_t  w,
    input  logic      w_ready,
    input  logic      b_valid,
    output logic      b_ready
);

    cpu_req_t held;
    logic     misaligned;
    xlen_t    load_value;
    xlen_t    amo_result;
    xlen_t    bus_addr;

    assign ar_addr = bus_addr;
    assign aw_addr = bus_addr;

    access_fsm access_fsm_i (
        .clk        (clk),
        .rstn       (rstn),
        .req_valid  (req_valid),
        .req        (req),
        .misaligned (misaligned),
        .load_value (load_value),
        .amo_result (amo_result),
        .ar_ready   (ar_ready),
        .r_valid    (r_valid),
        .aw_ready   (aw_ready),
        .w_ready    (w_ready),
        .b_valid    (b_valid),
        .req_ready  (req_ready),
        .resp_valid (resp_valid),
        .resp       (resp),
        .held       (held),
        .ar_valid   (ar_valid),
        .aw_valid   (aw_valid),
        .w_valid    (w_valid),
        .bus_addr   (bus_addr),
        .r_ready    (r_ready),
        .b_ready    (b_ready)
    );

    lane_aligner lane_aligner_i (
        .req_addr   (req.addr),
        .req_size   (req.size),
        .held       (held),
        .r_data     (r_data),
        .misaligned (misaligned),
        .load_value (load_value),
        .w          (w)
    );

    // Old value comes from the registered load result
    amo_alu amo_alu_i (
        .original (resp.value),
        .operand  (held.value),
        .fn       (held.amo),
        .result   (amo_result)
    );

endmodule

// File: source/uncached_pkg.sv
// Fixed 64-bit data path, single-beat bus only, AMO functions use the RISC-V funct5 encodings
package uncached_pkg;

    localparam int XLEN       = 64;
    localparam int BYTE_OFS_W = 3;   // Byte offset within a doubleword

    typedef logic [XLEN-1:0]   xlen_t;
    typedef logic [XLEN/8-1:0] strb_t;
    typedef logic [1:0]        size_t;   // 0 byte, 1 half, 2 word, 3 double

    typedef enum logic [1:0] {
        MEM_LOAD,
        MEM_STORE,
        MEM_SC,
        MEM_AMO
    } mem_op_t;

    typedef enum logic [4:0] {
        ADD  = 5'b00000,
        SWAP = 5'b00001,
        XOR  = 5'b00100,
        OR   = 5'b01000,
        AND  = 5'b01100,
        MIN  = 5'b10000,
        MAX  = 5'b10100,
        MINU = 5'b11000,
        MAXU = 5'b11100
    } amo_fn_t;

    typedef enum logic [3:0] {
        EXC_LOAD_MISALIGN  = 4'd4,
        EXC_STORE_MISALIGN = 4'd6   // Also used for SC and AMO
    } exc_cause_t;

    typedef struct packed {
        xlen_t   addr;
        xlen_t   value;        // Store data or AMO operand
        mem_op_t op;
        size_t   size;
        logic    is_unsigned;
        amo_fn_t amo;
    } cpu_req_t;

    typedef struct packed {
        xlen_t      value;
        logic       exc_valid;
        exc_cause_t exc_cause;
        xlen_t      tval;
    } cpu_resp_t;

    typedef struct packed {
        xlen_t data;
        strb_t strb;
    } wr_beat_t;

endpackage

// File: src.f
source/uncached_pkg.sv
source/lane_aligner.sv
source/amo_alu.sv
source/access_fsm.sv
source/uncached_dcache.sv
tests/bus_memory_model.sv
tests/tb_uncached_dcache.sv

// File: tests/bus_memory_model.sv
// Sixteen doublewords indexed by address bits 6:3; ready delays of 0 to 3 cycles from $random
module bus_memory_model import uncached_pkg::*; (
    input  logic     clk,
    input  logic     rstn,
    input  logic     ar_valid,
    input  xlen_t    ar_addr,
    output logic     ar_ready,
    output logic     r_valid,
    output xlen_t    r_data,
    input  logic     aw_valid,
    input  xlen_t    aw_addr,
    output logic     aw_ready,
    input  logic     w_valid,
    input  wr_beat_t w,
    output logic     w_ready,
    output logic     b_valid
);

    timeunit 1ns;
    timeprecision 1ps;

    localparam int DEPTH = 16;

    xlen_t  mem [DEPTH];
    integer seed = 32'ha662_ad82;
    int     ar_wait;
    int     aw_wait;
    int     w_wait;
    logic   aw_done;
    logic   w_done;

    function automatic int next_delay();
        next_delay = int'($unsigned($random(seed)) % 4);
    endfunction

    always @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            for (int i = 0; i < DEPTH; i++) begin
                mem[i] <= 64'h8877_6655_4433_2211 + 64'(i) * 64'h0101_0101_0101_0101;
            end
            ar_ready <= 1'b0;
            r_valid  <= 1'b0;
            r_data   <= '0;
            aw_ready <= 1'b0;
            w_ready  <= 1'b0;
            b_valid  <= 1'b0;
            aw_done  <= 1'b0;
            w_done   <= 1'b0;
            ar_wait  <= next_delay();
            aw_wait  <= next_delay();
            w_wait   <= next_delay();
        end else begin
            ar_ready <= 1'b0;
            r_valid  <= 1'b0;
            aw_ready <= 1'b0;
            w_ready  <= 1'b0;
            b_valid  <= 1'b0;
            if (ar_valid && ar_ready) begin
                r_valid <= 1'b1;   // Read beat one cycle after AR
                r_data  <= mem[ar_addr[6:3]];
                ar_wait <= next_delay();
            end else if (ar_valid) begin
                if (ar_wait == 0) ar_ready <= 1'b1;
                else ar_wait <= ar_wait - 1;
            end
            if (aw_valid && aw_ready) begin
                aw_done <= 1'b1;
                aw_wait <= next_delay();
            end else if (aw_valid && !aw_done) begin
                if (aw_wait == 0) aw_ready <= 1'b1;
                else aw_wait <= aw_wait - 1;
            end
            if (w_valid && w_ready) begin
                for (int b = 0; b < 8; b++) begin
                    if (w.strb[b]) mem[aw_addr[6:3]][b*8 +: 8] <= w.data[b*8 +: 8];
                end
                w_done <= 1'b1;
                w_wait <= next_delay();
            end else if (w_valid && !w_done) begin
                if (w_wait == 0) w_ready <= 1'b1;
                else w_wait <= w_wait - 1;
            end
            if (aw_done && w_done) begin
                b_valid <= 1'b1;
                aw_done <= 1'b0;
                w_done  <= 1'b0;
            end
        end
    end

endmodule

// File: tests/tb_uncached_dcache.sv
// Expected values assume the memory preload 8877_6655_4433_2211 plus index times 0101_0101_0101_0101
module tb_uncached_dcache import uncached_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    typedef struct packed {
        mem_op_t    op;
        xlen_t      addr;
        size_t      size;
        logic       is_unsigned;
        xlen_t      value;
        amo_fn_t    amo;
        logic       expect_exc;
        exc_cause_t cause;
        xlen_t      expected;
    } entry_t;

    localparam int N = 45;
    localparam exc_cause_t LC = EXC_LOAD_MISALIGN;
    localparam exc_cause_t SC = EXC_STORE_MISALIGN;

    localparam entry_t TABLE [N] = '{
        '{MEM_LOAD,  64'h07, 2'd0, 1'b0, 64'h0, ADD, 1'b0, LC, 64'hffff_ffff_ffff_ff88},
        '{MEM_LOAD,  64'h07, 2'd0, 1'b1, 64'h0, ADD, 1'b0, LC, 64'h0000_0000_0000_0088},
        '{MEM_LOAD,  64'h06, 2'd1, 1'b0, 64'h0, ADD, 1'b0, LC, 64'hffff_ffff_ffff_8877},
        '{MEM_LOAD,  64'h02, 2'd1, 1'b1, 64'h0, ADD, 1'b0, LC, 64'h0000_0000_0000_4433},
        '{MEM_LOAD,  64'h04, 2'd2, 1'b0, 64'h0, ADD, 1'b0, LC, 64'hffff_ffff_8877_6655},
        '{MEM_LOAD,  64'h04, 2'd2, 1'b1, 64'h0, ADD, 1'b0, LC, 64'h0000_0000_8877_6655},
        '{MEM_LOAD,  64'h00, 2'd2, 1'b0, 64'h0, ADD, 1'b0, LC, 64'h0000_0000_4433_2211},
        '{MEM_LOAD,  64'h08, 2'd3, 1'b0, 64'h0, ADD, 1'b0, LC, 64'h8978_6756_4534_2312},
        '{MEM_LOAD,  64'h01, 2'd0, 1'b0, 64'h0, ADD, 1'b0, LC, 64'h0000_0000_0000_0022},
        // Partial stores into doubleword 2
        '{MEM_STORE, 64'h15, 2'd0, 1'b0, 64'haa, ADD, 1'b0, LC, 64'h0},
        '{MEM_STORE, 64'h16, 2'd1, 1'b0, 64'hbeef, ADD, 1'b0, LC, 64'h0},
        '{MEM_STORE, 64'h10, 2'd2, 1'b0, 64'hffff_ffff_1234_5678, ADD, 1'b0, LC, 64'h0},
        '{MEM_LOAD,  64'h10, 2'd3, 1'b0, 64'h0, ADD, 1'b0, LC, 64'hbeef_aa57_1234_5678},
        '{MEM_STORE, 64'h18, 2'd3, 1'b0, 64'h0123_4567_89ab_cdef, ADD, 1'b0, LC, 64'h0},
        '{MEM_LOAD,  64'h18, 2'd3, 1'b0, 64'h0, ADD, 1'b0, LC, 64'h0123_4567_89ab_cdef},
        // Remaining lanes of doubleword 3
        '{MEM_LOAD,  64'h18, 2'd0, 1'b0, 64'h0, ADD, 1'b0, LC, 64'hffff_ffff_ffff_ffef},
        '{MEM_LOAD,  64'h19, 2'd0, 1'b1, 64'h0, ADD, 1'b0, LC, 64'h0000_0000_0000_00cd},
        '{MEM_LOAD,  64'h1a, 2'd0, 1'b0, 64'h0, ADD, 1'b0, LC, 64'hffff_ffff_ffff_ffab},
        '{MEM_LOAD,  64'h1b, 2'd0, 1'b1, 64'h0, ADD, 1'b0, LC, 64'h0000_0000_0000_0089},
        '{MEM_LOAD,  64'h1c, 2'd0, 1'b0, 64'h0, ADD, 1'b0, LC, 64'h0000_0000_0000_0067},
        '{MEM_LOAD,  64'h1d, 2'd0, 1'b1, 64'h0, ADD, 1'b0, LC, 64'h0000_0000_0000_0045},
        '{MEM_LOAD,  64'h1e, 2'd0, 1'b0, 64'h0, ADD, 1'b0, LC, 64'h0000_0000_0000_0023},
        '{MEM_LOAD,  64'h18, 2'd1, 1'b1, 64'h0, ADD, 1'b0, LC, 64'h0000_0000_0000_cdef},
        '{MEM_LOAD,  64'h1a, 2'd1, 1'b0, 64'h0, ADD, 1'b0, LC, 64'hffff_ffff_ffff_89ab},
        '{MEM_LOAD,  64'h1c, 2'd1, 1'b1, 64'h0, ADD, 1'b0, LC, 64'h0000_0000_0000_4567},
        '{MEM_LOAD,  64'h18, 2'd2, 1'b1, 64'h0, ADD, 1'b0, LC, 64'h0000_0000_89ab_cdef},
        '{MEM_LOAD,  64'h18, 2'd2, 1'b0, 64'h0, ADD, 1'b0, LC, 64'hffff_ffff_89ab_cdef},
        '{MEM_LOAD,  64'h21, 2'd1, 1'b0, 64'h0, ADD, 1'b1, LC, 64'h0},
        '{MEM_STORE, 64'h22, 2'd2, 1'b0, 64'h5, ADD, 1'b1, SC, 64'h0},
        '{MEM_LOAD,  64'h0c, 2'd3, 1'b0, 64'h0, ADD, 1'b1, LC, 64'h0},
        '{MEM_AMO,   64'h2a, 2'd3, 1'b0, 64'h1, ADD, 1'b1, SC, 64'h0},
        // AMO chain on doubleword 4
        '{MEM_AMO,   64'h20, 2'd3, 1'b0, 64'h1, ADD, 1'b0, LC, 64'h8c7b_6a59_4837_2615},
        '{MEM_AMO,   64'h20, 2'd3, 1'b0, 64'hff, XOR, 1'b0, LC, 64'h8c7b_6a59_4837_2616},
        '{MEM_AMO,   64'h20, 2'd3, 1'b0, 64'hffff_ffff_0000_0000, AND, 1'b0, LC,
          64'h8c7b_6a59_4837_26e9},
        '{MEM_AMO,   64'h20, 2'd3, 1'b0, 64'h0f, OR, 1'b0, LC, 64'h8c7b_6a59_0000_0000},
        '{MEM_AMO,   64'h20, 2'd3, 1'b0, 64'h5, MIN, 1'b0, LC, 64'h8c7b_6a59_0000_000f},
        '{MEM_AMO,   64'h20, 2'd3, 1'b0, 64'h5, MINU, 1'b0, LC, 64'h8c7b_6a59_0000_000f},
        '{MEM_AMO,   64'h20, 2'd3, 1'b0, 64'hffff_ffff_ffff_fffe, MAX, 1'b0, LC, 64'h5},
        '{MEM_AMO,   64'h20, 2'd3, 1'b0, 64'hffff_ffff_ffff_fffe, MAXU, 1'b0, LC, 64'h5},
        '{MEM_AMO,   64'h20, 2'd3, 1'b0, 64'h123, SWAP, 1'b0, LC, 64'hffff_ffff_ffff_fffe},
        '{MEM_LOAD,  64'h20, 2'd3, 1'b0, 64'h0, ADD, 1'b0, LC, 64'h123},
        '{MEM_AMO,   64'h2c, 2'd2, 1'b0, 64'h1, ADD, 1'b0, LC, 64'hffff_ffff_8d7c_6b5a},
        '{MEM_LOAD,  64'h28, 2'd3, 1'b0, 64'h0, ADD, 1'b0, LC, 64'h8d7c_6b5b_4938_2716},
        '{MEM_SC,    64'h30, 2'd3, 1'b0, 64'hcafe, ADD, 1'b0, LC, 64'h0},
        '{MEM_LOAD,  64'h30, 2'd3, 1'b0, 64'h0, ADD, 1'b0, LC, 64'hcafe}
    };

    logic      clk = 1'b0;
    logic      rstn;
    logic      req_valid;
    cpu_req_t  req;
    logic      req_ready;
    logic      resp_valid;
    cpu_resp_t resp;
    logic      ar_valid;
    xlen_t     ar_addr;
    logic      ar_ready;
    logic      r_valid;
    xlen_t     r_data;
    logic      r_ready;
    logic      aw_valid;
    xlen_t     aw_addr;
    logic      aw_ready;
    logic      w_valid;
    wr_beat_t  w;
    logic      w_ready;
    logic      b_valid;
    logic      b_ready;

    always #5 clk = ~clk;

    uncached_dcache uncached_dcache_i (.*);

    bus_memory_model bus_memory_model_i (.*);

    task automatic report_error(input string msg);
        $display("Fail at %0t: %s", $time, msg);
        $display("Testbench failed");
        $fatal(1);
    endtask

    task automatic check_value(input xlen_t got, input xlen_t exp, input string what);
        if (got !== exp) report_error($sformatf("%s is %h, expected %h", what, got, exp));
    endtask

    task automatic check_cause(input exc_cause_t got, input exc_cause_t exp, input string what);
        if (got !== exp) report_error($sformatf("%s is %0d, expected %0d", what, got, exp));
    endtask

    task automatic check_exc(input logic got, input logic exp, input string what);
        if (got !== exp) report_error($sformatf("%s is %b, expected %b", what, got, exp));
    endtask

    // Watchdog sized from the table length
    initial begin
        #((N * 20 + 2) * 10);
        $display("Timeout: the DUT stopped answering requests");
        $display("Testbench failed");
        $fatal(1);
    end

    initial begin
        int     cycles;
        entry_t e;
        rstn      = 1'b0;
        req_valid = 1'b0;
        req       = '0;
        repeat (2) @(posedge clk);
        rstn <= 1'b1;
        @(negedge clk);
        check_exc(req_ready, 1'b1, "req_ready after reset");
        check_exc(resp_valid, 1'b0, "resp_valid after reset");
        check_exc(resp.exc_valid, 1'b0, "exc_valid after reset");
        check_exc(ar_valid, 1'b0, "ar_valid after reset");
        check_exc(aw_valid, 1'b0, "aw_valid after reset");
        check_exc(w_valid, 1'b0, "w_valid after reset");
        for (int i = 0; i < N; i++) begin
            e = TABLE[i];
            @(posedge clk);
            req_valid       <= 1'b1;
            req.addr        <= e.addr;
            req.value       <= e.value;
            req.op          <= e.op;
            req.size        <= e.size;
            req.is_unsigned <= e.is_unsigned;
            req.amo         <= e.amo;
            @(posedge clk);   // Accepted here, the FSM is idle
            req_valid <= 1'b0;
            cycles = 0;
            forever begin
                @(negedge clk);
                cycles++;
                check_exc(r_ready, 1'b1, "r_ready");
                check_exc(b_ready, 1'b1, "b_ready");
                if (ar_valid) begin
                    check_value(ar_addr, e.addr, $sformatf("ar_addr in entry %0d", i));
                end
                if (aw_valid) begin
                    check_value(aw_addr, e.addr, $sformatf("aw_addr in entry %0d", i));
                end
                if (e.expect_exc) begin
                    check_exc(ar_valid, 1'b0, "ar_valid on misaligned access");
                    check_exc(aw_valid, 1'b0, "aw_valid on misaligned access");
                    check_exc(w_valid, 1'b0, "w_valid on misaligned access");
                end
                if (resp_valid) break;
                check_exc(req_ready, 1'b0, $sformatf("req_ready in entry %0d", i));
            end
            check_exc(resp.exc_valid, e.expect_exc, $sformatf("exc_valid in entry %0d", i));
            if (e.expect_exc) begin
                check_cause(resp.exc_cause, e.cause, $sformatf("cause in entry %0d", i));
                check_value(resp.tval, e.addr, $sformatf("tval in entry %0d", i));
                if (cycles != 1) report_error($sformatf("entry %0d answered after %0d cycles",
                                                        i, cycles));
            end else begin
                check_value(resp.value, e.expected, $sformatf("value in entry %0d", i));
            end
        end
        $display("Testbench passed");
        $finish;
    end

endmodule
